// File: compile.f
logic/vgaPkg.sv
logic/vgaTiming.sv
logic/pixelFetch.sv
logic/frameBufArbiter.sv
logic/frameBuffer.sv
logic/pixelOutput.sv
logic/vgaSubsystem.sv
bench/vgaSubsystem_checker.sv
bench/vgaSubsystem_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the display subsystem simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module vgaSubsystem_tb -f compile.f \
	--Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
exit 0

// File: bench/vgaSubsystem_tb.sv
/* Display subsystem testbench
   Random host writes and cursor settings checked against a frame model */
`timescale 1ns/10ps

module vgaSubsystem_tb;
	import vgaPkg::*;

	localparam int FRAME_CYC = 242;
	// Sync 2, image 4, cursor 2, back-pressure 4 frames, plus margin
	localparam int WATCHDOG_CYC = (12 + 3) * FRAME_CYC;

	logic       iCLK;
	logic       iRST_N;
	hostWrite   hostWr;
	logic       hostWrValid;
	logic       hostWrReady;
	cursorSetup cursor;
	rgbColor    rgb;
	logic       hSync;
	logic       vSync;
	logic       blankN;
	logic       underrun;

	rgbColor model [128];
	integer  seed = 53594;
	int      errorCount = 0;
	int      testCount = 0;
	int      testsFailed = 0;
	logic    sawNotReady;

	vgaSubsystem DUT (
		.iCLK, .iRST_N, .hostWr, .hostWrValid, .hostWrReady, .cursor,
		.rgb, .hSync, .vSync, .blankN, .underrun
	);

	initial
	begin
		iCLK = 1'b0;
		forever #5 iCLK = ~iCLK;
	end

	initial
	begin
		repeat (WATCHDOG_CYC) @(posedge iCLK);
		$display("Timeout, the tests did not finish in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic reportTest(input string name, input int startErrors);
		testCount++;
		if (errorCount == startErrors)
			$display("Test %0d %s: passed", testCount, name);
		else
		begin
			testsFailed++;
			$display("Test %0d %s: failed with %0d errors", testCount, name,
				errorCount - startErrors);
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Error %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	// Returns at the first negedge of a frame, with vSync just low
	task automatic waitFrameStart();
		@(negedge iCLK);
		while (!vSync)
			@(negedge iCLK);
		while (vSync)
			@(negedge iCLK);
	endtask

	function automatic rgbColor expectedPixel(input int k);
		int x;
		int y;
		int dx;
		int dy;
		x = k % 16;
		y = k / 16;
		dx = x - int'(cursor.x);
		dy = y - int'(cursor.y);
		if (cursor.enable && ((dx >= -1 && dx <= 1) || (dy >= -1 && dy <= 1)))
			return cursor.color;
		return model[k];
	endfunction

	// Compare one whole frame of active pixels, scan order from address 0
	task automatic checkImage();
		int k;
		rgbColor exp;
		waitFrameStart();
		k = 0;
		while (k < 128)
		begin
			@(negedge iCLK);
			if (blankN)
			begin
				exp = expectedPixel(k);
				if (rgb !== exp)
				begin
					$display("Error rgb at x=%0d y=%0d: got %h expected %h",
						k % 16, k / 16, rgb, exp);
					errorCount++;
				end
				k++;
			end
		end
	endtask

	// Called just after a rising edge, returns just after the accepting edge
	task automatic hostWriteOne(input fbAddr a, input rgbColor d);
		hostWr.addr = a;
		hostWr.data = d;
		hostWrValid = 1'b1;
		@(negedge iCLK);
		while (!hostWrReady)
		begin
			sawNotReady = 1'b1;
			@(negedge iCLK);
		end
		model[a[6:0]] = d;
		@(posedge iCLK);
		#1 hostWrValid = 1'b0;
	endtask

	task automatic checkSyncTiming();
		int hLow;
		int vLow;
		int bHigh;
		int bRuns;
		int lastHFall;
		int vFalls;
		logic prevH;
		logic prevV;
		logic prevB;
		waitFrameStart();
		hLow = 1;
		vLow = 1;
		bHigh = 0;
		bRuns = 0;
		lastHFall = 0;
		vFalls = 0;
		prevH = hSync;
		prevV = vSync;
		prevB = blankN;
		for (int cyc = 1; cyc < 2 * FRAME_CYC; cyc++)
		begin
			@(negedge iCLK);
			if (!hSync)
				hLow++;
			if (prevH && !hSync)
			begin
				checkValue("hSync period", cyc - lastHFall, 22);
				lastHFall = cyc;
			end
			if (!prevH && hSync)
			begin
				checkValue("hSync low pulse", hLow, 2);
				hLow = 0;
			end
			if (!vSync)
				vLow++;
			if (prevV && !vSync)
			begin
				checkValue("vSync period", cyc, FRAME_CYC);
				vFalls++;
			end
			if (!prevV && vSync)
			begin
				checkValue("vSync low pulse", vLow, 22);
				vLow = 0;
			end
			if (blankN)
				bHigh++;
			if (prevB && !blankN)
			begin
				checkValue("blankN high run", bHigh, 16);
				bRuns++;
				bHigh = 0;
			end
			prevH = hSync;
			prevV = vSync;
			prevB = blankN;
		end
		checkValue("vSync frame starts", vFalls, 1);
		checkValue("blankN runs in two frames", bRuns, 16);
	endtask

	initial
	begin
		int startErrors;
		int order [128];
		int j;
		int tmp;
		time tEnd;

		iRST_N = 1'b0;
		hostWr = '0;
		hostWrValid = 1'b0;
		cursor = '0;
		for (int i = 0; i < 128; i++)
			model[i] = '0;

		startErrors = errorCount;
		repeat (4) @(posedge iCLK);
		#1 iRST_N = 1'b1;
		// Reset values, sampled after release and before the next clock edge
		#1;
		checkValue("hSync", hSync, 1);
		checkValue("vSync", vSync, 1);
		checkValue("blankN", blankN, 0);
		checkValue("rgb", rgb, 0);
		checkValue("underrun", underrun, 0);
		checkValue("hostWrReady", hostWrReady, 1);
		reportTest("reset values", startErrors);

		startErrors = errorCount;
		checkSyncTiming();
		reportTest("sync timing", startErrors);

		// Every address once, in shuffled order
		startErrors = errorCount;
		for (int i = 0; i < 128; i++)
			order[i] = i;
		for (int i = 127; i > 0; i--)
		begin
			j = $unsigned($random(seed)) % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		@(posedge iCLK);
		#1;
		for (int i = 0; i < 128; i++)
			hostWriteOne(fbAddr'(order[i]), rgbColor'($random(seed)));
		// Skip a frame so that prefetched words are current
		waitFrameStart();
		checkImage();
		reportTest("image contents", startErrors);

		startErrors = errorCount;
		@(posedge iCLK);
		#1;
		cursor.enable = 1'b1;
		cursor.x = screenCoord'($unsigned($random(seed)) % 16);
		cursor.y = screenCoord'($unsigned($random(seed)) % 8);
		cursor.color = rgbColor'($random(seed));
		checkImage();
		@(posedge iCLK);
		#1 cursor.enable = 1'b0;
		checkImage();
		reportTest("cursor overlay", startErrors);

		// Writes for a whole frame, stalled through the active lines
		startErrors = errorCount;
		sawNotReady = 1'b0;
		waitFrameStart();
		@(posedge iCLK);
		#1;
		tEnd = $time + FRAME_CYC * 10;
		while ($time < tEnd)
			hostWriteOne(fbAddr'($unsigned($random(seed)) % 128), rgbColor'($random(seed)));
		if (!sawNotReady)
		begin
			$display("hostWrReady never went low during active lines");
			errorCount++;
		end
		waitFrameStart();
		checkImage();
		reportTest("host back-pressure", startErrors);

		startErrors = errorCount;
		checkValue("underrun", underrun, 0);
		reportTest("no underrun", startErrors);

		$display("%0d tests run, %0d failed, %0d errors", testCount, testsFailed, errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: bench/vgaSubsystem_checker.sv
/* Display subsystem port checker
   Blanking, underrun and host handshake rules on the top-level pins */
`timescale 1ns/10ps

module vgaSubsystem_checker (
	input logic             iCLK,
	input logic             iRST_N,
	input vgaPkg::rgbColor  rgb,
	input logic             blankN,
	input logic             underrun,
	input vgaPkg::hostWrite hostWr,
	input logic             hostWrValid,
	input logic             hostWrReady
);
	import vgaPkg::*;

	// Colour must be black outside the active area
	blankBlack: assert property (@(posedge iCLK) disable iff (!iRST_N)
		!blankN |-> (rgb == '0))
		else $error("rgb not zero during blanking");

	noUnderrun: assert property (@(posedge iCLK) disable iff (!iRST_N)
		!$rose(underrun))
		else $error("pixel queue underrun");

	// Host payload held until the write is taken
	hostHold: assert property (@(posedge iCLK) disable iff (!iRST_N)
		(hostWrValid && !hostWrReady) |=> $stable(hostWr))
		else $error("host write payload changed while stalled");

endmodule

bind vgaSubsystem vgaSubsystem_checker portChecks (
	.iCLK(iCLK), .iRST_N(iRST_N), .rgb(rgb), .blankN(blankN), .underrun(underrun),
	.hostWr(hostWr), .hostWrValid(hostWrValid), .hostWrReady(hostWrReady)
);

// File: logic/vgaSubsystem.sv
/* Display subsystem top
   Timing, fetch, shared frame buffer and output stage wired together */
`timescale 1ns/10ps

module vgaSubsystem #(
	parameter int H_SYNC      = 2,
	parameter int H_BACK      = 2,
	parameter int H_ACTIVE    = 16,
	parameter int H_FRONT     = 2,
	parameter int V_SYNC      = 1,
	parameter int V_BACK      = 1,
	parameter int V_ACTIVE    = 8,
	parameter int V_FRONT     = 1,
	parameter int FB_DEPTH    = H_ACTIVE * V_ACTIVE,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic               iCLK,
	input  logic               iRST_N,
	input  vgaPkg::hostWrite   hostWr,
	input  logic               hostWrValid,
	output logic               hostWrReady,
	input  vgaPkg::cursorSetup cursor,
	output vgaPkg::rgbColor    rgb,
	output logic               hSync,
	output logic               vSync,
	output logic               blankN,
	output logic               underrun
);
	import vgaPkg::*;

	beamState beam;
	logic     creditReturn;
	logic     rdReq;
	fbAddr    rdAddr;
	fbRequest memReq;
	logic     memEn;
	logic     rdValid;
	rgbColor  rdData;

	vgaTiming #(
		.H_SYNC(H_SYNC), .H_BACK(H_BACK), .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT),
		.V_SYNC(V_SYNC), .V_BACK(V_BACK), .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT)
	) timing (.iCLK, .iRST_N, .beam);

	pixelFetch #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .QUEUE_DEPTH(QUEUE_DEPTH)) fetch (
		.iCLK, .iRST_N, .creditReturn, .rdReq, .rdAddr
	);

	frameBufArbiter arbiter (
		.iCLK, .iRST_N, .rdReq, .rdAddr, .hostWr, .hostWrValid, .hostWrReady,
		.memReq, .memEn, .rdValid
	);

	frameBuffer #(.FB_DEPTH(FB_DEPTH)) fbRam (.iCLK, .memReq, .memEn, .rdData);

	pixelOutput #(.QUEUE_DEPTH(QUEUE_DEPTH)) outStage (
		.iCLK, .iRST_N, .beam, .rdValid, .rdData, .cursor, .creditReturn,
		.rgb, .hSync, .vSync, .blankN, .underrun
	);

endmodule

// File: logic/pixelOutput.sv
/* Display output stage
   Pixel queue with credit return, crosshair overlay and registered VGA pins */
`timescale 1ns/10ps

module pixelOutput #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic               iCLK,
	input  logic               iRST_N,
	input  vgaPkg::beamState   beam,
	input  logic               rdValid,
	input  vgaPkg::rgbColor    rdData,
	input  vgaPkg::cursorSetup cursor,
	output logic               creditReturn,
	output vgaPkg::rgbColor    rgb,
	output logic               hSync,
	output logic               vSync,
	output logic               blankN,
	output logic               underrun
);
	import vgaPkg::*;

	localparam int QW = $clog2(QUEUE_DEPTH);
	localparam int CW = $clog2(QUEUE_DEPTH + 1);

	rgbColor       queue [QUEUE_DEPTH];
	logic [QW-1:0] wrPtr;
	logic [QW-1:0] rdPtr;
	logic [CW-1:0] count;
	logic          pop;
	logic          popOk;
	logic [8:0]    beamX;
	logic [8:0]    beamY;
	logic [8:0]    curX;
	logic [8:0]    curY;
	logic          onCursor;
	rgbColor       pixel;

	// One pixel leaves per active beam cycle, its slot goes back as a credit
	assign pop          = beam.active;
	assign popOk        = pop && (count != '0);
	assign creditReturn = pop;

	always_ff @(posedge iCLK)
	begin
		if (rdValid)
		begin
			queue[wrPtr] <= rdData;
		end
	end

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			count    <= '0;
			underrun <= 1'b0;
		end
		else
		begin
			if (rdValid)
				wrPtr <= (wrPtr == QW'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (popOk)
				rdPtr <= (rdPtr == QW'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			count <= count + CW'(rdValid) - CW'(popOk);
			// Sticky, display needed a pixel that had not arrived
			if (pop && (count == '0))
				underrun <= 1'b1;
		end
	end

	// Crosshair is three pixels wide in each direction
	assign beamX    = {1'b0, beam.x};
	assign beamY    = {1'b0, beam.y};
	assign curX     = {1'b0, cursor.x};
	assign curY     = {1'b0, cursor.y};
	assign onCursor = cursor.enable &&
		(((beamX + 9'd1 >= curX) && (beamX <= curX + 9'd1)) ||
		 ((beamY + 9'd1 >= curY) && (beamY <= curY + 9'd1)));

	assign pixel = !beam.active ? '0 : (onCursor ? cursor.color : queue[rdPtr]);

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			hSync  <= 1'b1;
			vSync  <= 1'b1;
			blankN <= 1'b0;
			rgb    <= '0;
		end
		else
		begin
			hSync  <= beam.hSync;
			vSync  <= beam.vSync;
			blankN <= beam.active;
			rgb    <= pixel;
		end
	end

endmodule

// File: logic/frameBuffer.sv
/* Single-port frame buffer RAM with a registered read */
`timescale 1ns/10ps

module frameBuffer #(
	parameter int FB_DEPTH = 256
) (
	input  logic             iCLK,
	input  vgaPkg::fbRequest memReq,
	input  logic             memEn,
	output vgaPkg::rgbColor  rdData
);
	import vgaPkg::*;

	localparam int AW = $clog2(FB_DEPTH);

	rgbColor mem [FB_DEPTH];

	// One access per clock, write or read
	always_ff @(posedge iCLK)
	begin
		if (memEn)
		begin
			if (memReq.write)
			begin
				mem[memReq.addr[AW-1:0]] <= memReq.data;
			end
			else
			begin
				rdData <= mem[memReq.addr[AW-1:0]];
			end
		end
	end

endmodule

// File: logic/frameBufArbiter.sv
/* Frame buffer port arbiter
   Display reads take the port first, host writes use the idle cycles */
`timescale 1ns/10ps

module frameBufArbiter (
	input  logic             iCLK,
	input  logic             iRST_N,
	input  logic             rdReq,
	input  vgaPkg::fbAddr    rdAddr,
	input  vgaPkg::hostWrite hostWr,
	input  logic             hostWrValid,
	output logic             hostWrReady,
	output vgaPkg::fbRequest memReq,
	output logic             memEn,
	output logic             rdValid
);

	// Host waits whenever the display holds the port
	assign hostWrReady = !rdReq;

	always_comb
	begin
		if (rdReq)
		begin
			memReq.write = 1'b0;
			memReq.addr  = rdAddr;
		end
		else
		begin
			memReq.write = hostWrValid;
			memReq.addr  = hostWr.addr;
		end
		// Data is ignored by the memory on reads
		memReq.data = hostWr.data;
	end

	assign memEn = rdReq || hostWrValid;

	// Read data comes back one clock after the grant
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			rdValid <= 1'b0;
		end
		else
		begin
			rdValid <= rdReq;
		end
	end

endmodule

// File: logic/pixelFetch.sv
/* Display read address generator
   Walks the frame buffer in scan order, one read per free queue slot */
`timescale 1ns/10ps

module pixelFetch #(
	parameter int H_ACTIVE    = 16,
	parameter int V_ACTIVE    = 8,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic          iCLK,
	input  logic          iRST_N,
	input  logic          creditReturn,
	output logic          rdReq,
	output vgaPkg::fbAddr rdAddr
);
	import vgaPkg::*;

	localparam int CW = $clog2(QUEUE_DEPTH + 1);
	localparam fbAddr LAST_ADDR = fbAddr'(H_ACTIVE * V_ACTIVE - 1);

	logic [CW-1:0] credits;
	logic [CW-1:0] creditsNext;

	// Spend on issue, refill on return, both may land together
	always_comb
	begin
		creditsNext = credits;
		if (rdReq)
		begin
			creditsNext = creditsNext - 1'b1;
		end
		if (creditReturn)
		begin
			creditsNext = creditsNext + 1'b1;
		end
	end

	// rdReq tracks the credit count one register later
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			credits <= CW'(QUEUE_DEPTH);
			rdReq   <= 1'b0;
		end
		else
		begin
			credits <= creditsNext;
			rdReq   <= (creditsNext != '0);
		end
	end

	// Scan address wraps at the end of the visible frame
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			rdAddr <= '0;
		end
		else if (rdReq)
		begin
			rdAddr <= (rdAddr == LAST_ADDR) ? '0 : rdAddr + 1'b1;
		end
	end

endmodule

// File: logic/vgaTiming.sv
/* Raster timing generator
   Line and frame counters, low-going syncs, active flag and beam position */
`timescale 1ns/10ps

module vgaTiming #(
	parameter int H_SYNC   = 2,
	parameter int H_BACK   = 2,
	parameter int H_ACTIVE = 16,
	parameter int H_FRONT  = 2,
	parameter int V_SYNC   = 1,
	parameter int V_BACK   = 1,
	parameter int V_ACTIVE = 8,
	parameter int V_FRONT  = 1
) (
	input  logic             iCLK,
	input  logic             iRST_N,
	output vgaPkg::beamState beam
);
	import vgaPkg::*;

	localparam int H_TOTAL = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
	localparam int V_TOTAL = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;
	localparam int HW      = $clog2(H_TOTAL);
	localparam int VW      = $clog2(V_TOTAL);
	localparam int X_START = H_SYNC + H_BACK;
	localparam int Y_START = V_SYNC + V_BACK;

	logic [HW-1:0] hCount;
	logic [VW-1:0] vCount;
	logic          lineEnd;
	logic          hActive;
	logic          vActive;

	assign lineEnd = (hCount == HW'(H_TOTAL - 1));

	// Horizontal count steps every clock, vertical count once per line
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else
		begin
			hCount <= lineEnd ? '0 : hCount + 1'b1;
			if (lineEnd)
			begin
				vCount <= (vCount == VW'(V_TOTAL - 1)) ? '0 : vCount + 1'b1;
			end
		end
	end

	assign hActive = (hCount >= HW'(X_START)) && (hCount < HW'(X_START + H_ACTIVE));
	assign vActive = (vCount >= VW'(Y_START)) && (vCount < VW'(Y_START + V_ACTIVE));

	always_comb
	begin
		beam.hSync  = (hCount >= HW'(H_SYNC));
		beam.vSync  = (vCount >= VW'(V_SYNC));
		beam.active = hActive && vActive;
		// Position only meaningful inside the active area
		beam.x      = screenCoord'(hCount - HW'(X_START));
		beam.y      = screenCoord'(vCount - VW'(Y_START));
	end

endmodule

// File: logic/vgaPkg.sv
/* Display subsystem shared types
   Colours, coordinates, frame-buffer addresses and bus payloads */
package vgaPkg;

	// 4 bits each of red, green and blue
	typedef logic [11:0] rgbColor;

	// Column or row inside the active area
	typedef logic [7:0] screenCoord;

	// Frame-buffer word address, row times width plus column
	typedef logic [7:0] fbAddr;

	// Timing generator output, one sample per clock
	typedef struct packed {
		logic       hSync;
		logic       vSync;
		logic       active;
		screenCoord x;
		screenCoord y;
	} beamState;

	// Single memory port request
	typedef struct packed {
		logic    write;
		fbAddr   addr;
		rgbColor data;
	} fbRequest;

	typedef struct packed {
		fbAddr   addr;
		rgbColor data;
	} hostWrite;

	// Crosshair cursor control
	typedef struct packed {
		logic       enable;
		screenCoord x;
		screenCoord y;
		rgbColor    color;
	} cursorSetup;

endpackage
